// ==== mem_system.f ====
source/cache_geom_pkg.sv
source/mem_ctrl_pkg.sv
source/mem_sys_ifs.sv
source/request_decode.sv
source/cache_array.sv
source/cache_ctrl.sv
source/backing_mem.sv
source/mem_system.sv
tb/mem_system_chk.sv
tb/mem_system_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --assert --top-module mem_system_tb -f mem_system.f -o mem_system_sim \
   > build.log 2>&1 \
   && ./obj_dir/mem_system_sim +verilator+error+limit+100 > sim.log 2>&1 \
   || echo "ERRORS FOUND" >> sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed, see sim.log"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }

// ==== tb/mem_system_tb.sv ====
// Testbench for mem_system that checks directed and random requests against a cache and memory model
`timescale 1ns/1ps

module mem_system_tb import cache_geom_pkg::*; ();

   localparam int MEM_LATENCY = 3;
   localparam int NUM_REQS    = 216;
   // Worst case per request is a dirty miss with eight transfers
   localparam int CYCLE_LIMIT = NUM_REQS * (10 + 8 * (MEM_LATENCY + 1)) + 100;

   // Expected outcome of one request
   typedef struct packed {
      word_t data;
      logic  hit;
      logic  err;
      logic  chk_data;
      logic  fast;
   } expect_t;

   logic  clk = 1'b0;
   logic  rst;
   addr_t addr;
   word_t data_in;
   logic  rd;
   logic  wr;
   word_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   // Reference state of flat memory plus line tags
   word_t       model_mem [addr_t];
   logic        line_valid [NUM_LINES];
   tag_t        line_tag [NUM_LINES];
   expect_t     exp_q [$];
   logic [31:0] rng = 32'hf8e7;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          test_base = 0;
   int          cycles = 0;
   int          lat = 0;
   logic        pending = 1'b0;
   int          total;

   mem_system #(.MEM_LATENCY(MEM_LATENCY)) uut (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Predicts one request and updates the model
   function automatic expect_t predict(input logic r, input logic w, input addr_t a,
                                       input word_t d);
      expect_t e;
      addr_t   wa;
      index_t  idx;
      tag_t    tg;
      e   = '0;
      wa  = {1'b0, a[15:1]};
      idx = a[10:3];
      tg  = a[15:11];
      if ((r && w) || a[0]) begin
         // Rejected request changes nothing
         e.err  = 1'b1;
         e.fast = 1'b1;
      end else begin
         e.hit  = line_valid[idx] && (line_tag[idx] == tg);
         e.fast = e.hit;
         // Write allocate leaves the line resident
         line_valid[idx] = 1'b1;
         line_tag[idx]   = tg;
         if (w) begin
            model_mem[wa] = d;
         end else begin
            e.chk_data = 1'b1;
            e.data     = model_mem.exists(wa) ? model_mem[wa] : mem_init_word(wa);
         end
      end
      return e;
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Drives one request, releases the strobes at the accepting edge and waits for done
   task automatic run_request(input logic r, input logic w, input addr_t a, input word_t d);
      exp_q.push_back(predict(r, w, a, d));
      @(posedge clk);
      rd      <= r;
      wr      <= w;
      addr    <= a;
      data_in <= d;
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
      @(negedge clk);
      while (!done) @(negedge clk);
   endtask

   task automatic report_test(input string name);
      // Let the compare process finish the last request
      @(posedge clk);
      tests_run++;
      if (errors == test_base) begin
         $display("Test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: %0d mismatches", tests_run, name, errors - test_base);
      end
      test_base = errors;
   endtask

   // Four tags on four indexes force frequent evictions
   task automatic run_random(input int count);
      addr_t a;
      word_t d;
      logic  w;
      for (int n = 0; n < count; n++) begin
         rng = lcg_next(rng);
         a   = {3'b011, rng[17:16], 6'b001011, rng[19:18], rng[21:20], 1'b0};
         w   = rng[24];
         rng = lcg_next(rng);
         d   = rng[31:16];
         run_request(!w, w, a, d);
      end
   endtask

   // Checks each result as done rises
   // lat counts edges since the accepting edge
   always @(negedge clk) begin
      expect_t e;
      if ((rd || wr) && !stall) begin
         lat     = -1;
         pending = 1'b1;
      end else begin
         lat = lat + 1;
      end
      // Busy from the cycle after acceptance until the result
      if (pending && lat >= 0 && !done) check_flag("stall", stall, 1'b1);
      if (done) begin
         pending = 1'b0;
         check_flag("stall", stall, 1'b0);
         if (exp_q.size() == 0) begin
            $display("done seen with no request outstanding");
            errors++;
         end else begin
            e = exp_q.pop_front();
            check_flag("err", err, e.err);
            check_flag("cache_hit", cache_hit, e.hit);
            if (e.chk_data) check_word("data_out", data_out, e.data);
            // Hits and rejects finish two cycles after acceptance
            if (e.fast && lat != 2) begin
               $display("done came %0d cycles after acceptance instead of 2", lat);
               errors++;
            end
         end
      end
   end

   // Hang guard
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial begin
      rst     = 1'b1;
      rd      = 1'b0;
      wr      = 1'b0;
      addr    = '0;
      data_in = '0;
      for (int i = 0; i < NUM_LINES; i++) begin
         line_valid[i] = 1'b0;
      end
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      run_request(1'b1, 1'b0, 16'h1234, 16'h0000);
      run_request(1'b1, 1'b0, 16'h1234, 16'h0000);
      report_test("read miss then hit");

      run_request(1'b0, 1'b1, 16'h1234, 16'hbeef);
      run_request(1'b1, 1'b0, 16'h1234, 16'h0000);
      report_test("write hit");

      // Same index with a tag that differs in bit 15
      run_request(1'b0, 1'b1, 16'h2a48, 16'hc0de);
      run_request(1'b1, 1'b0, 16'haa48, 16'h0000);
      run_request(1'b1, 1'b0, 16'h2a48, 16'h0000);
      report_test("dirty eviction");

      run_request(1'b0, 1'b1, 16'h6e14, 16'h1357);
      for (int k = 0; k < 4; k++) begin
         run_request(1'b1, 1'b0, 16'h6e10 + addr_t'(2 * k), 16'h0000);
      end
      report_test("write miss allocate");

      run_request(1'b1, 1'b1, 16'h1234, 16'hdead);
      run_request(1'b0, 1'b1, 16'h1235, 16'hdead);
      run_request(1'b1, 1'b0, 16'h1237, 16'h0000);
      run_request(1'b1, 1'b0, 16'h1234, 16'h0000);
      report_test("illegal requests");

      run_random(200);
      report_test("random mix");

      if (exp_q.size() != 0) begin
         $display("%0d requests never finished", exp_q.size());
         errors++;
      end
      total = errors + int'(uut.u_ctrl.u_chk.fail_count);
      $display("Tests %0d, failed %0d, check errors %0d, assertion failures %0d",
               tests_run, tests_failed, errors, uut.u_ctrl.u_chk.fail_count);
      if (total == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== tb/mem_system_chk.sv ====
// Assertions bound into cache_ctrl that watch the Wishbone handshake and the result outputs
`timescale 1ns/1ps

module mem_system_chk import cache_geom_pkg::*; (
   input logic  clk,
   input logic  rst,
   input logic  cyc,
   input logic  stb,
   input logic  ack,
   input addr_t adr,
   input logic  done,
   input logic  stall
);

   // Read by the testbench at the end of the run
   int unsigned fail_count = 0;

   // Slave answers only an active strobe
   ack_in_strobe: assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb))
      else begin
         $error("ack raised without cyc and stb");
         fail_count++;
      end

   // Master holds the transfer until ack
   stb_held: assert property (@(posedge clk) disable iff (rst)
      (stb && !ack) |=> (stb && $stable(adr)))
      else begin
         $error("stb or adr changed before ack");
         fail_count++;
      end

   // Single-cycle result pulse
   done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else begin
         $error("done high for more than one cycle");
         fail_count++;
      end

   done_no_stall: assert property (@(posedge clk) disable iff (rst) done |-> !stall)
      else begin
         $error("stall high together with done");
         fail_count++;
      end

endmodule

bind cache_ctrl mem_system_chk u_chk (
   .clk   (clk),
   .rst   (rst),
   .cyc   (wb.cyc),
   .stb   (wb.stb),
   .ack   (wb.ack),
   .adr   (wb.adr),
   .done  (done),
   .stall (stall)
);

// ==== source/mem_system.sv ====
// Top of the data memory subsystem, wiring decoder, controller, cache storage and memory
`timescale 1ns/1ps

module mem_system import cache_geom_pkg::*, mem_ctrl_pkg::*; #(
   parameter int MEM_LATENCY = 3
) (
   input  logic  clk,
   input  logic  rst,
   input  addr_t addr,
   input  word_t data_in,
   input  logic  rd,
   input  logic  wr,
   output word_t data_out,
   output logic  done,
   output logic  stall,
   output logic  cache_hit,
   output logic  err
);

   // Decoder to controller handshake
   mem_req_t req;
   logic     req_valid;
   logic     req_taken;

   wb_if    wb ();
   cache_if cache ();

   request_decode u_decode (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .req_taken (req_taken),
      .req       (req),
      .req_valid (req_valid)
   );

   cache_ctrl u_ctrl (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .req_valid (req_valid),
      .req_taken (req_taken),
      .cache     (cache.master),
      .wb        (wb.master),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   cache_array u_cache (
      .clk   (clk),
      .rst   (rst),
      .cache (cache.slave)
   );

   backing_mem #(.MEM_LATENCY(MEM_LATENCY)) u_mem (
      .clk (clk),
      .rst (rst),
      .wb  (wb.slave)
   );

endmodule

// ==== source/backing_mem.sv ====
// Backing word memory answering as a Wishbone classic slave after MEM_LATENCY cycles
`timescale 1ns/1ps

module backing_mem import cache_geom_pkg::*; #(
   parameter int MEM_LATENCY = 3
) (
   input logic clk,
   input logic rst,
   wb_if.slave wb
);

   localparam int CNT_W = $clog2(MEM_LATENCY + 1);

   word_t            mem [MEM_WORDS];
   logic [CNT_W-1:0] lat_cnt;
   logic             fire;

   // Latency reached on this cycle of the strobe
   assign fire = wb.cyc && wb.stb && !wb.ack && (int'(lat_cnt) + 1 == MEM_LATENCY);

   // Known content from time zero
   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = mem_init_word(addr_t'(i));
      end
   end

   // Latency counter and single-cycle ack
   always_ff @(posedge clk) begin
      if (rst) begin
         lat_cnt <= '0;
         wb.ack  <= 1'b0;
      end else begin
         wb.ack <= fire;
         if (fire || !(wb.cyc && wb.stb) || wb.ack) begin
            lat_cnt <= '0;
         end else begin
            lat_cnt <= lat_cnt + 1'b1;
         end
      end
   end

   // Access happens at the edge that raises ack
   always @(posedge clk) begin
      if (fire) begin
         if (wb.we) begin
            mem[wb.adr[15:1]] <= wb.dat_m2s;
         end
         wb.dat_s2m <= mem[wb.adr[15:1]];
      end
   end

endmodule

// ==== source/cache_ctrl.sv ====
// Cache controller FSM: compare, writeback and refill over Wishbone, and the result registers
`timescale 1ns/1ps

module cache_ctrl import cache_geom_pkg::*, mem_ctrl_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  mem_req_t req,
   input  logic     req_valid,
   output logic     req_taken,
   cache_if.master  cache,
   wb_if.master     wb,
   output word_t    data_out,
   output logic     done,
   output logic     stall,
   output logic     cache_hit,
   output logic     err
);

   ctrl_state_t state;
   mem_req_t    cur;
   // Word counter for writeback and refill
   offset_t     cnt;

   // Busy from the cycle after acceptance up to the result cycle
   assign stall = req_valid || (state != S_IDLE && state != S_RESULT);

   // Writeback data comes straight out of the cache
   assign wb.dat_m2s = cache.rdata;

   // Cache and bus controls per state
   always_comb begin
      req_taken      = 1'b0;
      cache.en       = 1'b0;
      cache.comp     = 1'b0;
      cache.write    = 1'b0;
      cache.valid_in = 1'b0;
      cache.index    = cur.index;
      cache.tag      = cur.tag;
      cache.offset   = cur.offset;
      cache.wdata    = cur.wdata;
      wb.cyc         = 1'b0;
      wb.stb         = 1'b0;
      wb.we          = 1'b0;
      wb.adr         = '0;
      case (state)
         S_IDLE: req_taken = req_valid;
         // Also the final access after refill, which must hit
         S_COMPARE, S_FINISH: begin
            cache.en    = cur.op != OP_ILLEGAL;
            cache.comp  = 1'b1;
            cache.write = cur.op == OP_WRITE;
         end
         S_WRITEBACK: begin
            cache.en     = 1'b1;
            cache.offset = cnt;
            wb.cyc       = 1'b1;
            wb.stb       = 1'b1;
            wb.we        = 1'b1;
            // Victim address rebuilt from the stored tag
            wb.adr       = {cache.tag_out, cur.index, cnt, 1'b0};
         end
         S_REFILL: begin
            wb.cyc         = 1'b1;
            wb.stb         = 1'b1;
            wb.adr         = {cur.tag, cur.index, cnt, 1'b0};
            // Install each word as it is acknowledged
            cache.en       = wb.ack;
            cache.write    = wb.ack;
            cache.valid_in = 1'b1;
            cache.offset   = cnt;
            cache.wdata    = wb.dat_s2m;
         end
         default: ;
      endcase
   end

   // FSM and result flags
   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= S_IDLE;
         cnt       <= '0;
         done      <= 1'b0;
         cache_hit <= 1'b0;
         err       <= 1'b0;
      end else begin
         // Result flags are single-cycle pulses
         done      <= 1'b0;
         cache_hit <= 1'b0;
         err       <= 1'b0;
         case (state)
            S_IDLE: if (req_valid) state <= S_COMPARE;
            S_COMPARE: begin
               if (cur.op == OP_ILLEGAL) begin
                  err   <= 1'b1;
                  done  <= 1'b1;
                  state <= S_RESULT;
               end else if (cache.hit) begin
                  done      <= 1'b1;
                  cache_hit <= 1'b1;
                  state     <= S_RESULT;
               end else begin
                  cnt   <= '0;
                  state <= (cache.valid && cache.dirty) ? S_WRITEBACK : S_REFILL;
               end
            end
            S_WRITEBACK: begin
               if (wb.ack) begin
                  cnt <= cnt + 1'b1;
                  if (cnt == 2'd3) state <= S_REFILL;
               end
            end
            S_REFILL: begin
               if (wb.ack) begin
                  cnt <= cnt + 1'b1;
                  if (cnt == 2'd3) state <= S_FINISH;
               end
            end
            // Miss served, reported without cache_hit
            S_FINISH: begin
               done  <= 1'b1;
               state <= S_RESULT;
            end
            S_RESULT: state <= S_IDLE;
            default: state <= S_IDLE;
         endcase
      end
   end

   // Current request and read data
   always_ff @(posedge clk) begin
      if (state == S_IDLE && req_valid) cur <= req;
      if (cur.op == OP_READ && ((state == S_COMPARE && cache.hit) || state == S_FINISH)) begin
         data_out <= cache.rdata;
      end
   end

endmodule

// ==== source/cache_array.sv ====
// Direct-mapped cache storage with tag compare, driven by the controller through cache_if
`timescale 1ns/1ps

module cache_array import cache_geom_pkg::*; (
   input logic    clk,
   input logic    rst,
   cache_if.slave cache
);

   // Per-line state
   tag_t               tag_mem   [NUM_LINES];
   logic [NUM_LINES-1:0] valid_mem;
   logic [NUM_LINES-1:0] dirty_mem;
   word_t              data_mem  [NUM_LINES][WORDS_PER_LINE];

   logic tag_match;
   logic do_write;
   logic install;

   // Read side is purely combinational
   assign cache.valid   = valid_mem[cache.index];
   assign cache.dirty   = dirty_mem[cache.index];
   assign cache.tag_out = tag_mem[cache.index];
   assign cache.rdata   = data_mem[cache.index][cache.offset];

   assign tag_match = tag_mem[cache.index] == cache.tag;
   assign cache.hit = cache.en && cache.comp && cache.valid && tag_match;

   // Compare write only lands on a hit; install always lands
   assign install  = cache.en && cache.write && !cache.comp;
   assign do_write = install || (cache.write && cache.hit);

   // Valid bits are the only state cleared by reset
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_mem <= '0;
      end else if (install) begin
         valid_mem[cache.index] <= cache.valid_in;
      end
   end

   // Tag, dirty and data
   always_ff @(posedge clk) begin
      if (do_write) begin
         data_mem[cache.index][cache.offset] <= cache.wdata;
      end
      if (install) begin
         tag_mem[cache.index]   <= cache.tag;
         dirty_mem[cache.index] <= 1'b0;
      end else if (do_write) begin
         // Processor write marks the line for writeback
         dirty_mem[cache.index] <= 1'b1;
      end
   end

endmodule

// ==== source/request_decode.sv ====
// Front stage that registers one processor request and hands it to the cache controller
`timescale 1ns/1ps

module request_decode import cache_geom_pkg::*, mem_ctrl_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  addr_t    addr,
   input  word_t    data_in,
   input  logic     rd,
   input  logic     wr,
   input  logic     req_taken,
   output mem_req_t req,
   output logic     req_valid
);

   // Both strobes or an odd address make the request illegal
   logic bad_req;

   assign bad_req = (rd && wr) || addr[0];

   // Handshake flag towards the controller
   always_ff @(posedge clk) begin
      if (rst) begin
         req_valid <= 1'b0;
      end else if (req_valid && req_taken) begin
         req_valid <= 1'b0;
      end else if (!req_valid && (rd || wr)) begin
         req_valid <= 1'b1;
      end
   end

   // Request payload, captured on acceptance only
   always_ff @(posedge clk) begin
      if (!req_valid && (rd || wr)) begin
         req.op     <= bad_req ? OP_ILLEGAL : (wr ? OP_WRITE : OP_READ);
         req.tag    <= addr[15:11];
         req.index  <= addr[10:3];
         req.offset <= addr[2:1];
         req.wdata  <= data_in;
      end
   end

endmodule

// ==== source/mem_sys_ifs.sv ====
// Wishbone classic link and cache storage port, instantiated once each by the top level
`timescale 1ns/1ps

// Wishbone classic, one transfer at a time
interface wb_if import cache_geom_pkg::*; ();
   logic  cyc;
   logic  stb;
   logic  we;
   addr_t adr;
   word_t dat_m2s;
   word_t dat_s2m;
   logic  ack;

   modport master (output cyc, stb, we, adr, dat_m2s, input dat_s2m, ack);
   modport slave (input cyc, stb, we, adr, dat_m2s, output dat_s2m, ack);
endinterface

// Tag compare and word access into the cache storage
interface cache_if import cache_geom_pkg::*; ();
   logic    en, comp, write, valid_in;
   index_t  index;
   tag_t    tag;
   offset_t offset;
   word_t   wdata;
   logic    hit, valid, dirty;
   tag_t    tag_out;
   word_t   rdata;

   modport master (output en, comp, write, valid_in, index, tag, offset, wdata,
                   input hit, valid, dirty, tag_out, rdata);
   modport slave (input en, comp, write, valid_in, index, tag, offset, wdata,
                  output hit, valid, dirty, tag_out, rdata);
endinterface

// ==== source/mem_ctrl_pkg.sv ====
// Request and controller FSM types used by the decoder, the cache controller and its checker
package mem_ctrl_pkg;

   import cache_geom_pkg::*;

   // Operation class found by the decoder
   typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_ILLEGAL} op_t;

   // Registered request, address already split
   typedef struct packed {
      op_t     op;
      tag_t    tag;
      index_t  index;
      offset_t offset;
      word_t   wdata;
   } mem_req_t;

   // Controller FSM states
   typedef enum logic [2:0] {
      S_IDLE, S_COMPARE, S_WRITEBACK, S_REFILL, S_FINISH, S_RESULT
   } ctrl_state_t;

endpackage

// ==== source/cache_geom_pkg.sv ====
// Cache and address geometry shared by decode, cache storage, controller and backing memory
package cache_geom_pkg;

   // Byte address and data word
   typedef logic [15:0] addr_t;
   typedef logic [15:0] word_t;

   // Address split is tag 15:11, index 10:3, offset 2:1, bit 0 always zero
   typedef logic [4:0] tag_t;
   typedef logic [7:0] index_t;
   typedef logic [1:0] offset_t;

   // Direct-mapped, four words per line
   localparam int WORDS_PER_LINE = 4;
   localparam int NUM_LINES      = 256;

   // Backing memory covers the full 64 KB byte space
   localparam int MEM_WORDS = 32768;

   // Power-up content of a word, keyed by word address (byte address >> 1)
   function automatic word_t mem_init_word(input addr_t waddr);
      return waddr ^ 16'h5a3c;
   endfunction

endpackage
